// ==== flist.f ====
+incdir+test
rtl/sa_pkg.sv
rtl/pe.sv
rtl/pe_array.sv
rtl/row_readout.sv
rtl/systolic_top.sv
test/tb_systolic.sv

// ==== test/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

////////////////////
// edge operands seen inside the grid
////////////////////

// one pixel of column col at an enabled step
function automatic int pixel_at(input int step, input int col, input bit upper);
    logic signed [PIXEL_W-1:0] p;
    if (step < 0) begin
        return 0;                       // forwarding registers start cleared
    end
    if (upper) begin
        p = step_col[step][COL_IN_W*col + PIXEL_W +: PIXEL_W];
    end else begin
        p = step_col[step][COL_IN_W*col +: PIXEL_W];
    end
    return int'(p);
endfunction

// weight sel of row at an enabled step, decoded by mode
function automatic int weight_at(
    input int       step,
    input int       row,
    input int       sel,
    input sa_mode_e m
);
    logic [ROW_IN_W-1:0]        raw;
    logic signed [WEIGHT_W-1:0] w;
    if (step < 0) begin
        return 0;
    end
    raw = step_row[step][ROW_IN_W*row +: ROW_IN_W];
    if (m == mode_1x8) begin
        return raw[sel] ? -1 : 1;       // set bit means -1
    end
    w = raw;
    return (sel == 0) ? int'(w) : 0;    // only one weight in mode 0
endfunction

////////////////////
// accumulators and row packing
////////////////////

// element (i, j) after n_steps enabled edges
function automatic pe_acc_t element_acc(input int i, input int j, input sa_mode_e m);
    logic [ACC88_W-1:0] lane_lo;
    logic [ACC88_W-1:0] lane_hi;
    logic [ACC18_W-1:0] f [4];
    int                 p_lo;
    int                 p_hi;
    int                 w0;
    int                 w1;
    pe_acc_t            r;
    lane_lo = '0;
    lane_hi = '0;
    for (int k = 0; k < 4; k++) begin
        f[k] = '0;
    end
    // pixels arrive i steps late, weights j steps late
    for (int s = 0; s < n_steps; s++) begin
        p_lo = pixel_at(s - i, j, 1'b0);
        p_hi = pixel_at(s - i, j, 1'b1);
        w0   = weight_at(s - j, i, 0, m);
        w1   = weight_at(s - j, i, 1, m);
        lane_lo = lane_lo + ACC88_W'(p_lo * w0);   // 24 bit wrap
        lane_hi = lane_hi + ACC88_W'(p_hi * w0);
        f[0] = f[0] + ACC18_W'(p_lo * w0);         // 16 bit wrap
        f[1] = f[1] + ACC18_W'(p_hi * w0);
        f[2] = f[2] + ACC18_W'(p_lo * w1);
        f[3] = f[3] + ACC18_W'(p_hi * w1);
    end
    r = '0;
    if (m == mode_8x8) begin
        r[ACC88_W-1:0]            = lane_lo;
        r[ACC88_PAIR_W-1:ACC88_W] = lane_hi;
    end else begin
        r = {f[3], f[2], f[1], f[0]};
    end
    return r;
endfunction

// whole output bus for one row
function automatic logic [OUT_W-1:0] expected_row(input int row, input sa_mode_e m);
    logic [OUT_W-1:0] o;
    pe_acc_t          e;
    o = '0;
    for (int c = 0; c < COLS; c++) begin
        e = element_acc(row, c, m);
        if (m == mode_8x8) begin
            o[ACC88_PAIR_W*c +: ACC88_PAIR_W] = e[ACC88_PAIR_W-1:0];
        end else begin
            o[ACC18_PAIR_W*c +: ACC18_PAIR_W]          = {e.f1, e.f0};
            o[ACC18_PAIR_W*(COLS + c) +: ACC18_PAIR_W] = {e.f3, e.f2};
        end
    end
    return o;
endfunction

`endif

// ==== test/tb_systolic.sv ====
module tb_systolic
    import sa_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ROWS        = 4;
    localparam int COLS        = 4;
    localparam int OUT_W       = PE_OUT_W * COLS;
    localparam int T_SHORT     = 12;
    localparam int T_LONG      = 800;                 // long enough for 24 bit wrap
    localparam int DRAIN       = ROWS + COLS - 2;
    localparam int MAX_STEPS   = T_LONG + DRAIN;
    localparam int NUM_TESTS   = 8;
    localparam int CYCLE_LIMIT = NUM_TESTS * (T_LONG + ROWS + COLS + ROWS + 10);

    logic                     clk = 1'b0;
    logic                     channel_out_reset;
    logic                     acc_clear;
    logic                     en;
    sa_mode_e                 mode;
    logic                     channel_out_en;
    logic [ROW_IN_W*ROWS-1:0] row_in;
    logic [COL_IN_W*COLS-1:0] column_in;
    logic [OUT_W-1:0]         out;

    // edge inputs of the enabled steps of one channel
    logic [ROW_IN_W*ROWS-1:0] step_row [MAX_STEPS];
    logic [COL_IN_W*COLS-1:0] step_col [MAX_STEPS];
    int                       n_steps = 0;

    integer seed         = 32'h8c16_c925;
    int     err_cnt      = 0;
    int     check_cnt    = 0;
    int     err_mark     = 0;
    int     chk_mark     = 0;
    int     cycle_cnt    = 0;
    int     rows_checked = 0;
    int     model_row    = -1;                        // -1 is idle
    bit     pulse_seen   = 1'b0;
    bit     idle_probe   = 1'b0;

    `include "tb_ref_model.svh"

    systolic_top #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) u_dut (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .acc_clear         (acc_clear),
        .en                (en),
        .mode              (mode),
        .channel_out_en    (channel_out_en),
        .row_in            (row_in),
        .column_in         (column_in),
        .out               (out)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    ////////////////////
    // comparison
    ////////////////////

    task automatic compare_out(input logic [OUT_W-1:0] expected, input string where);
        check_cnt = check_cnt + 1;
        if (out !== expected) begin
            err_cnt = err_cnt + 1;
            $display("ERR out %s: expected %h, got %h", where, expected, out);
        end
    endtask

    // readout counter as the rules give it, first pulse selects row 0
    always @(posedge clk) begin
        pulse_seen <= channel_out_en;
        if (channel_out_reset) begin
            model_row <= -1;
        end else if (channel_out_en) begin
            model_row <= model_row + 1;
        end
    end

    // out settles after the edge, so look at it mid cycle
    always @(negedge clk) begin
        if (pulse_seen) begin
            compare_out(expected_row(model_row, mode), $sformatf("row %0d", model_row));
            rows_checked = rows_checked + 1;
        end else if (idle_probe && model_row < 0) begin
            compare_out('0, "idle");
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("timeout: tests still running after %0d cycles", cycle_cnt);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    // mostly base, now and then the other extreme
    function automatic logic [7:0] pick_extreme(input logic [7:0] base, input logic [7:0] rare);
        return (($random(seed) & 15) == 0) ? rare : base;
    endfunction

    task automatic fill_stimulus(input int t_len, input bit extreme);
        n_steps = t_len + DRAIN;
        for (int s = 0; s < n_steps; s++) begin
            step_row[s] = '0;                         // drain steps stay zero
            step_col[s] = '0;
            if (s < t_len) begin
                for (int r = 0; r < ROWS; r++) begin
                    step_row[s][ROW_IN_W*r +: ROW_IN_W] =
                        extreme ? pick_extreme(8'h80, 8'h7f) : 8'($random(seed));
                end
                for (int c = 0; c < COLS; c++) begin
                    step_col[s][COL_IN_W*c +: PIXEL_W] =
                        extreme ? pick_extreme(8'h80, 8'h7f) : 8'($random(seed));
                    step_col[s][COL_IN_W*c + PIXEL_W +: PIXEL_W] =
                        extreme ? pick_extreme(8'h7f, 8'h80) : 8'($random(seed));
                end
            end
        end
    endtask

    task automatic stream_inputs(input bit gaps);
        int                       gap;
        logic [ROW_IN_W*ROWS-1:0] junk_row;
        logic [COL_IN_W*COLS-1:0] junk_col;
        for (int s = 0; s < n_steps; s++) begin
            gap = gaps ? ($random(seed) & 3) : 0;
            repeat (gap) begin
                // junk while disabled, must not reach the accumulators
                for (int b = 0; b < ROWS; b++) begin
                    junk_row[ROW_IN_W*b +: ROW_IN_W] = $random(seed);
                end
                for (int b = 0; b < COLS; b++) begin
                    junk_col[COL_IN_W*b +: COL_IN_W] = $random(seed);
                end
                @(posedge clk);
                en        <= 1'b0;
                row_in    <= junk_row;
                column_in <= junk_col;
            end
            @(posedge clk);
            en        <= 1'b1;
            row_in    <= step_row[s];
            column_in <= step_col[s];
        end
        @(posedge clk);
        en        <= 1'b0;
        row_in    <= '0;
        column_in <= '0;
    endtask

    task automatic read_rows();
        for (int r = 0; r < ROWS; r++) begin
            @(posedge clk);
            channel_out_en <= 1'b1;
        end
        @(posedge clk);
        channel_out_en <= 1'b0;
        wait (rows_checked == ROWS);
    endtask

    // one output channel: clear, stream, drain, optional readout
    task automatic run_channel(
        input sa_mode_e m,
        input int       t_len,
        input bit       extreme,
        input bit       gaps,
        input bit       do_read
    );
        fill_stimulus(t_len, extreme);
        @(posedge clk);
        acc_clear         <= 1'b1;
        channel_out_reset <= 1'b1;
        en                <= 1'b0;
        mode              <= m;
        @(posedge clk);
        acc_clear         <= 1'b0;
        channel_out_reset <= 1'b0;
        idle_probe        <= 1'b1;
        rows_checked = 0;
        stream_inputs(gaps);
        repeat (2) @(posedge clk);                    // still idle, out stays zero
        idle_probe <= 1'b0;
        if (do_read) begin
            read_rows();
        end
    endtask

    task automatic report_test(input int num, input string name);
        int errs;
        int chks;
        errs = err_cnt - err_mark;
        chks = check_cnt - chk_mark;
        if (chks == 0) begin
            err_cnt = err_cnt + 1;
            errs    = errs + 1;
            $display("test %0d ran no checks at all", num);
        end
        $display("test %0d %s: %s, %0d checks, %0d errors",
                 num, name, (errs == 0) ? "ok" : "failed", chks, errs);
        err_mark = err_cnt;
        chk_mark = check_cnt;
    endtask

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        channel_out_reset = 1'b1;
        acc_clear         = 1'b1;
        en                = 1'b0;
        mode              = mode_8x8;
        channel_out_en    = 1'b0;
        row_in            = '0;
        column_in         = '0;
        repeat (2) @(posedge clk);
        channel_out_reset <= 1'b0;
        acc_clear         <= 1'b0;

        run_channel(mode_8x8, T_SHORT, 1'b0, 1'b0, 1'b0);
        report_test(1, "idle output after reset");
        run_channel(mode_8x8, T_SHORT, 1'b0, 1'b0, 1'b1);
        report_test(2, "mode 0 random");
        run_channel(mode_1x8, T_SHORT, 1'b0, 1'b0, 1'b1);
        report_test(3, "mode 1 random");
        run_channel(mode_8x8, T_SHORT, 1'b0, 1'b1, 1'b1);
        report_test(4, "mode 0 enable gaps");
        run_channel(mode_1x8, T_SHORT, 1'b0, 1'b1, 1'b1);
        report_test(5, "mode 1 enable gaps");
        run_channel(mode_8x8, T_LONG, 1'b1, 1'b0, 1'b1);
        report_test(6, "mode 0 extreme wrap");
        run_channel(mode_1x8, T_LONG, 1'b1, 1'b0, 1'b1);
        report_test(7, "mode 1 extreme wrap");
        // second channel must show nothing of the first
        run_channel(mode_8x8, T_SHORT, 1'b0, 1'b0, 1'b1);
        run_channel(mode_1x8, T_SHORT, 1'b0, 1'b0, 1'b1);
        report_test(8, "clear with mode change");

        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/systolic_top.sv ====
module systolic_top
    import sa_pkg::*;
#(
    parameter  int ROWS  = 4,
    parameter  int COLS  = 4,
    localparam int OUT_W = PE_OUT_W * COLS
) (
    input  logic                      clk,
    input  logic                      channel_out_reset,
    input  logic                      acc_clear,
    input  logic                      en,
    input  sa_mode_e                  mode,
    input  logic                      channel_out_en,
    input  logic [ROW_IN_W*ROWS-1:0]  row_in,      // skewed by the driver
    input  logic [COL_IN_W*COLS-1:0]  column_in,   // skewed by the driver
    output logic [OUT_W-1:0]          out
);

    ////////////////////
    // array to readout
    ////////////////////

    pe_acc_t acc_grid [ROWS-1:0][COLS-1:0];

    pe_array #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) u_pe_array (
        .clk       (clk),
        .acc_clear (acc_clear),
        .en        (en),
        .mode      (mode),
        .row_in    (row_in),
        .column_in (column_in),
        .acc_grid  (acc_grid)
    );

    // one row per channel_out_en pulse
    row_readout #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) u_row_readout (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .channel_out_en    (channel_out_en),
        .mode              (mode),
        .acc_grid          (acc_grid),
        .out               (out)
    );

endmodule

// ==== rtl/row_readout.sv ====
module row_readout
    import sa_pkg::*;
#(
    parameter  int ROWS  = 4,
    parameter  int COLS  = 4,
    localparam int OUT_W = PE_OUT_W * COLS
) (
    input  logic              clk,
    input  logic              channel_out_reset,
    input  logic              channel_out_en,
    input  sa_mode_e          mode,
    input  pe_acc_t           acc_grid [ROWS-1:0][COLS-1:0],
    output logic [OUT_W-1:0]  out
);

    ////////////////////
    // row counter
    ////////////////////

    localparam int               CNT_W    = $clog2(ROWS + 1);
    localparam logic [CNT_W-1:0] ROW_IDLE = '1;   // all ones, nothing selected

    logic [CNT_W-1:0] row_cnt;

    // first pulse after reset wraps idle to row 0
    always_ff @(posedge clk) begin
        if (channel_out_reset) begin
            row_cnt <= ROW_IDLE;
        end else if (channel_out_en) begin
            row_cnt <= row_cnt + 1'b1;
        end
    end

    ////////////////////
    // row select
    ////////////////////

    pe_acc_t sel_row [COLS-1:0];

    // idle never matches a row since all ones is at least ROWS
    always_comb begin
        for (int c = 0; c < COLS; c++) begin
            sel_row[c] = '0;
        end
        for (int r = 0; r < ROWS; r++) begin
            if (row_cnt == CNT_W'(r)) begin
                for (int c = 0; c < COLS; c++) begin
                    sel_row[c] = acc_grid[r][c];
                end
            end
        end
    end

    ////////////////////
    // output packing
    ////////////////////

    always_comb begin
        out = '0;
        for (int c = 0; c < COLS; c++) begin
            if (mode == mode_8x8) begin
                // 48 bits per column, top of bus stays zero
                out[ACC88_PAIR_W*c +: ACC88_PAIR_W] = sel_row[c][ACC88_PAIR_W-1:0];
            end else begin
                // w0 results in the lower half of the bus
                out[ACC18_PAIR_W*c +: ACC18_PAIR_W] = {sel_row[c].f1, sel_row[c].f0};
                // w1 results in the upper half
                out[ACC18_PAIR_W*(COLS + c) +: ACC18_PAIR_W] =
                    {sel_row[c].f3, sel_row[c].f2};
            end
        end
    end

endmodule

// ==== rtl/pe_array.sv ====
module pe_array
    import sa_pkg::*;
#(
    parameter int ROWS = 4,
    parameter int COLS = 4
) (
    input  logic                       clk,
    input  logic                       acc_clear,
    input  logic                       en,
    input  sa_mode_e                   mode,
    input  logic [ROW_IN_W*ROWS-1:0]   row_in,      // weights, one byte per row
    input  logic [COL_IN_W*COLS-1:0]   column_in,   // pixel pairs, one per column
    output pe_acc_t                    acc_grid [ROWS-1:0][COLS-1:0]
);

    ////////////////////
    // links
    ////////////////////

    // pix_link[i][j] feeds row i, row 0 from the top edge
    pixel_pair_t pix_link [ROWS:0][COLS-1:0];
    // wgt_link[i][j] feeds column j, column 0 from the left edge
    weight_op_t  wgt_link [ROWS-1:0][COLS:0];

    ////////////////////
    // edge formatting
    ////////////////////

    // one row byte into the horizontal link format
    function automatic weight_op_t format_weight(
        input sa_mode_e              m,
        input logic [ROW_IN_W-1:0]   raw
    );
        weight_op_t w;
        if (m == mode_8x8) begin
            w.w1 = '0;
            w.w0 = raw;                      // signed weight as is
        end else begin
            // low two bits are two binary weights
            w.w0 = raw[0] ? BIN_NEG : BIN_POS;
            w.w1 = raw[1] ? BIN_NEG : BIN_POS;
        end
        return w;
    endfunction

    // left edge
    for (genvar i = 0; i < ROWS; i++) begin : g_left
        assign wgt_link[i][0] = format_weight(mode, row_in[ROW_IN_W*i +: ROW_IN_W]);
    end

    // top edge, upper byte is hi
    for (genvar j = 0; j < COLS; j++) begin : g_top
        assign pix_link[0][j] = pixel_pair_t'(column_in[COL_IN_W*j +: COL_IN_W]);
    end

    ////////////////////
    // grid
    ////////////////////

    // input skew is the driver's job, the grid only forwards
    // last row bottom and last column right go nowhere
    for (genvar i = 0; i < ROWS; i++) begin : g_row
        for (genvar j = 0; j < COLS; j++) begin : g_col
            pe u_pe (
                .clk       (clk),
                .acc_clear (acc_clear),
                .en        (en),
                .mode      (mode),
                .up        (pix_link[i][j]),
                .left      (wgt_link[i][j]),
                .bottom    (pix_link[i+1][j]),
                .right     (wgt_link[i][j+1]),
                .acc       (acc_grid[i][j])
            );
        end
    end

endmodule

// ==== rtl/pe.sv ====
module pe
    import sa_pkg::*;
(
    input  logic        clk,
    input  logic        acc_clear,
    input  logic        en,
    input  sa_mode_e    mode,
    input  pixel_pair_t up,
    input  weight_op_t  left,
    output pixel_pair_t bottom,
    output weight_op_t  right,
    output pe_acc_t     acc
);

    ////////////////////
    // products
    ////////////////////

    // one multiply per lane, no operand packing
    logic signed [PROD_W-1:0] prod_lo_w0;
    logic signed [PROD_W-1:0] prod_hi_w0;
    logic signed [PROD_W-1:0] prod_lo_w1;
    logic signed [PROD_W-1:0] prod_hi_w1;

    assign prod_lo_w0 = $signed(up.lo) * $signed(left.w0);
    assign prod_hi_w0 = $signed(up.hi) * $signed(left.w0);
    assign prod_lo_w1 = $signed(up.lo) * $signed(left.w1);  // zero in mode 0
    assign prod_hi_w1 = $signed(up.hi) * $signed(left.w1);

    ////////////////////
    // accumulate
    ////////////////////

    pe_acc_t             acc_q;
    pe_acc_t             acc_next;
    logic [ACC88_W-1:0]  lane_lo_88;   // mode 0 lanes
    logic [ACC88_W-1:0]  lane_hi_88;

    // mode 0 view of the accumulator register
    assign lane_lo_88 = acc_q[ACC88_W-1:0] + ACC88_W'(prod_lo_w0);
    assign lane_hi_88 = acc_q[ACC88_PAIR_W-1:ACC88_W] + ACC88_W'(prod_hi_w0);

    always_comb begin
        if (mode == mode_8x8) begin
            // upper field unused in this mode, kept at zero
            acc_next = pe_acc_t'({{(PE_OUT_W - ACC88_PAIR_W){1'b0}},
                                  lane_hi_88, lane_lo_88});
        end else begin
            // four 16 bit lanes, each wraps on its own
            acc_next.f0 = acc_q.f0 + ACC18_W'(prod_lo_w0);
            acc_next.f1 = acc_q.f1 + ACC18_W'(prod_hi_w0);
            acc_next.f2 = acc_q.f2 + ACC18_W'(prod_lo_w1);
            acc_next.f3 = acc_q.f3 + ACC18_W'(prod_hi_w1);
        end
    end

    ////////////////////
    // registers
    ////////////////////

    // operands move on one step per enabled edge, same edge as the add
    always_ff @(posedge clk) begin
        if (acc_clear) begin
            bottom <= '0;
            right  <= '0;
            acc_q  <= '0;
        end else if (en) begin
            bottom <= up;     // to the element below
            right  <= left;   // to the element on the right
            acc_q  <= acc_next;
        end
    end

    assign acc = acc_q;

endmodule

// ==== rtl/sa_pkg.sv ====
package sa_pkg;

    ////////////////////
    // operand and accumulator widths
    ////////////////////

    localparam int PIXEL_W  = 8;
    localparam int WEIGHT_W = 8;
    localparam int HEADROOM = 8;                     // accumulator growth bits

    localparam int PROD_W   = PIXEL_W + WEIGHT_W;    // full 8x8 product
    localparam int ACC88_W  = PROD_W + HEADROOM;     // 24, mode 0 lane
    localparam int ACC18_W  = PIXEL_W + HEADROOM;    // 16, mode 1 lane
    localparam int PE_OUT_W = 4 * ACC18_W;           // mode 1 is the wider case

    // both mode 0 lanes side by side
    localparam int ACC88_PAIR_W = 2 * ACC88_W;
    // two mode 1 fields, one pixel half of a column
    localparam int ACC18_PAIR_W = 2 * ACC18_W;

    // edge input slices
    localparam int ROW_IN_W = WEIGHT_W;              // one weight byte per row
    localparam int COL_IN_W = 2 * PIXEL_W;           // pixel pair per column

    ////////////////////
    // binary weight encoding, mode 1
    ////////////////////

    // raw bit 0 means +1, raw bit 1 means -1
    localparam logic signed [WEIGHT_W-1:0] BIN_POS = 8'sh01;
    localparam logic signed [WEIGHT_W-1:0] BIN_NEG = 8'shff;

    ////////////////////
    // modes
    ////////////////////

    typedef enum logic {
        mode_8x8 = 1'b0,   // signed weight times two pixels
        mode_1x8 = 1'b1    // two binary weights times two pixels
    } sa_mode_e;

    ////////////////////
    // grid links
    ////////////////////

    // vertical link, hi in the upper byte of column_in
    typedef struct packed {
        logic signed [PIXEL_W-1:0] hi;
        logic signed [PIXEL_W-1:0] lo;
    } pixel_pair_t;

    // horizontal link
    // mode 0: w0 carries the weight, w1 stays zero
    // mode 1: each field is +1 or -1
    typedef struct packed {
        logic signed [WEIGHT_W-1:0] w1;
        logic signed [WEIGHT_W-1:0] w0;
    } weight_op_t;

    // per element result
    // mode 0: bits 47:24 acc_hi, bits 23:0 acc_lo, top field zero
    // mode 1: f3 hi*w1, f2 lo*w1, f1 hi*w0, f0 lo*w0
    typedef struct packed {
        logic [ACC18_W-1:0] f3;
        logic [ACC18_W-1:0] f2;
        logic [ACC18_W-1:0] f1;
        logic [ACC18_W-1:0] f0;
    } pe_acc_t;

endpackage
